// File: Makefile
# Verilator build and run of the 2x line upscaler testbench

TOP = tb_scaler

.PHONY: all lint clean

# Build, run, and pass only if the pass line shows up
all:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "No errors"

lint:
	verilator --lint-only --timing --top-module scaler_top -f flist.f

clean:
	rm -rf obj_dir

// File: flist.f
src/scaler_pkg.sv
src/pix_if.sv
src/op_if.sv
src/scaler_in_port.sv
src/scaler_fifo.sv
src/scaler_interp.sv
src/scaler_ctl.sv
src/scaler_out_port.sv
src/scaler_top.sv
tb/tb_scaler.sv

// File: src/op_if.sv
`timescale 1ns/1ps
`default_nettype none

// Four-phase opcode channel, control to interpolator
interface op_if;
	import scaler_pkg::*;

	logic			req;	// Opcode valid
	logic			ack;	// Opcode executed
	interp_op_t		op;		// Opcode
	scale_mode_t	mode;	// Mode of the current line

	modport master
	(
		output	req,
		output	op,
		output	mode,
		input	ack
	);

	modport slave
	(
		input	req,
		input	op,
		input	mode,
		output	ack
	);

endinterface

`default_nettype wire

// File: src/pix_if.sv
`timescale 1ns/1ps
`default_nettype none

// Four-phase pixel stream
interface pix_if;
	import scaler_pkg::*;

	logic	req;		// Pixel valid, held until ack
	logic	ack;		// Pixel taken
	pixel_t	dat;		// Pixel data, stable while req
	logic	last;		// Last pixel of line

	modport sender
	(
		output	req,
		output	dat,
		output	last,
		input	ack
	);

	modport receiver
	(
		input	req,
		input	dat,
		input	last,
		output	ack
	);

endinterface

`default_nettype wire

// File: src/scaler_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_ctl
#(
	parameter P_LINE_LEN = 16						// Input pixels per line
)
(
	input wire							RST_IN,		// Clock
	input wire							CLK_IN,		// Reset
	input wire scaler_pkg::scale_mode_t	mode,		// Requested mode
	input wire							empty,		// FIFO empty
	output logic						rd,			// FIFO pop
	op_if.master						op			// Opcodes to interpolator
);

import scaler_pkg::*;

localparam P_CNT_W = $clog2(P_LINE_LEN + 1);
localparam logic [P_CNT_W-1:0] P_CNT_END = P_CNT_W'(P_LINE_LEN);

ctl_state_t			state;
logic [P_CNT_W-1:0]	cnt;		// Pixels popped in this line

// Pop with the ack, the flush consumes nothing
	assign rd = (state == ST_WAIT_ACK) && op.ack && (op.op != OP_FLUSH);

	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			state	<= ST_IDLE;
			cnt		<= 0;
			op.req	<= 0;
			op.op	<= OP_LOAD;
			op.mode	<= MODE_NEAREST;
		end
		else
		begin
			case (state)
				ST_IDLE :
				begin
					// First pixel of a line, mode fixed here
					if (!empty)
					begin
						op.mode	<= mode;
						op.op	<= OP_LOAD;
						op.req	<= 1;
						state	<= ST_WAIT_ACK;
					end
				end
				ST_ISSUE :
				begin
					if (!empty)
					begin
						op.op	<= OP_PAIR;
						op.req	<= 1;
						state	<= ST_WAIT_ACK;
					end
				end
				ST_WAIT_ACK :
				begin
					if (op.ack)
					begin
						op.req <= 0;
						if (rd)
							cnt <= cnt + 1'b1;
						state <= ST_WAIT_DROP;
					end
				end
				default :
				begin
					if (!op.ack)
					begin
						if (op.op == OP_FLUSH)
						begin
							cnt		<= 0;		// Line done
							state	<= ST_IDLE;
						end
						else if (cnt == P_CNT_END)
						begin
							op.op	<= OP_FLUSH;	// No FIFO data needed
							op.req	<= 1;
							state	<= ST_WAIT_ACK;
						end
						else
							state <= ST_ISSUE;
					end
				end
			endcase
		end
	end

// Interpolator acks only a pending opcode
	assert property (@(posedge RST_IN) disable iff (CLK_IN)
		$rose(op.ack) |-> op.req)
		else $error("Opcode ack without a request");

endmodule

`default_nettype wire

// File: src/scaler_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_fifo
#(
	parameter P_FIFO_ADR = 3					// Address width
)
(
	input wire						RST_IN,		// Clock
	input wire						CLK_IN,		// Reset
	input wire						wr,			// Write
	input wire scaler_pkg::pixel_t	wr_dat,		// Write data
	input wire						rd,			// Pop head
	output scaler_pkg::pixel_t		head,		// Show-ahead head word
	output logic					empty,		// No words
	output logic					full		// All words used
);

import scaler_pkg::*;

localparam P_WRDS = 2**P_FIFO_ADR;
localparam logic [P_FIFO_ADR:0] P_CNT_FULL = P_WRDS;

pixel_t					mem [0:P_WRDS-1];	// Distributed storage
logic [P_FIFO_ADR-1:0]	wp;					// Write pointer
logic [P_FIFO_ADR-1:0]	rp;					// Read pointer
logic [P_FIFO_ADR:0]	cnt;				// Used words

// Storage, written at the write pointer
	always_ff @(posedge RST_IN)
	begin
		if (wr)
			mem[wp] <= wr_dat;
	end

// Pointers wrap at the power of two
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			wp <= 0;
			rp <= 0;
		end
		else
		begin
			if (wr)
				wp <= wp + 1'b1;
			if (rd)
				rp <= rp + 1'b1;
		end
	end

// Word count
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			cnt <= 0;
		else
		begin
			case ({wr, rd})
				2'b10 :		cnt <= cnt + 1'b1;
				2'b01 :		cnt <= cnt - 1'b1;
				default :	cnt <= cnt;		// Idle or both
			endcase
		end
	end

// Status and head
	assign empty	= (cnt == 0);
	assign full		= (cnt == P_CNT_FULL);
	assign head		= mem[rp];		// Valid when not empty

// Callers must respect the status flags
	assert property (@(posedge RST_IN) disable iff (CLK_IN) rd |-> !empty)
		else $error("FIFO read while empty");

	assert property (@(posedge RST_IN) disable iff (CLK_IN) wr |-> !full)
		else $error("FIFO write while full");

endmodule

`default_nettype wire

// File: src/scaler_in_port.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_in_port
(
	input wire						RST_IN,		// Clock
	input wire						CLK_IN,		// Reset
	input wire						in_req,		// Input pixel request
	output logic					in_ack,		// Input pixel acknowledge
	input wire scaler_pkg::pixel_t	in_dat,		// Input pixel
	input wire						full,		// FIFO full
	output logic					wr,			// FIFO write
	output scaler_pkg::pixel_t		wr_dat		// FIFO write data
);

logic req_del;		// Request, one cycle late
logic req_re;		// Request rising edge
logic pend;			// Edge seen while FIFO was full

// Request edge detector
	assign req_re = in_req && !req_del;

// Write on a new request once there is room
	assign wr = (req_re || pend) && !full;
	assign wr_dat = in_dat;		// Sender holds data while req is high

	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			req_del	<= 0;
			pend	<= 0;
			in_ack	<= 0;
		end
		else
		begin
			req_del <= in_req;

			// Keep the request until the FIFO drains
			pend <= (req_re || pend) && full;

			// Ack with the write, release after req drops
			if (wr)
				in_ack <= 1;
			else if (!in_req)
				in_ack <= 0;
		end
	end

// One write per request
	assert property (@(posedge RST_IN) disable iff (CLK_IN)
		wr |-> !in_ack)
		else $error("FIFO write while in_ack still high");

endmodule

`default_nettype wire

// File: src/scaler_interp.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_interp
(
	input wire						RST_IN,		// Clock
	input wire						CLK_IN,		// Reset
	input wire scaler_pkg::pixel_t	head,		// FIFO head pixel
	op_if.slave						op,			// Opcodes from control
	pix_if.sender					out			// Output pixel stream
);

import scaler_pkg::*;

// Output sequencer states
typedef enum logic [2:0]
{
	SND_IDLE,
	SND_EVEN,			// Even pixel offered
	SND_EVEN_DROP,		// Waiting for even ack release
	SND_ODD,			// Odd pixel offered
	SND_ODD_DROP,		// Waiting for odd ack release
	SND_DONE			// Opcode acked, waiting for req drop
} snd_state_t;

snd_state_t	state;
pixel_t		prev;		// Previous input pixel
pixel_t		odd;		// Odd output pixel
logic		ld_prev;	// Latch head as previous
logic		ld_even;	// Load even pixel to output
logic		ld_odd;		// Load odd pixel to output

// Rounded average of two components, carry kept
	function automatic comp_t avg(input comp_t a, input comp_t b);
		logic [8:0] sum;
		sum = {1'b0, a} + {1'b0, b} + 9'd1;
		return sum[8:1];
	endfunction

// Odd pixel, head is stable until control pops it
	always_comb
	begin
		if ((op.op == OP_PAIR) && (op.mode == MODE_LINEAR))
		begin
			odd.r = avg(prev.r, head.r);
			odd.g = avg(prev.g, head.g);
			odd.b = avg(prev.b, head.b);
		end
		else
			odd = prev;		// Nearest, or flush duplicate
	end

// Load strobes
	assign ld_even	= (state == SND_IDLE) && op.req && (op.op != OP_LOAD);
	assign ld_odd	= (state == SND_EVEN_DROP) && !out.ack;
	assign ld_prev	= ((state == SND_IDLE) && op.req && (op.op == OP_LOAD)) ||
					  ((state == SND_ODD_DROP) && !out.ack && (op.op == OP_PAIR));

// Payload
	always_ff @(posedge RST_IN)
	begin
		if (ld_prev)
			prev <= head;

		if (ld_even)
		begin
			out.dat		<= prev;
			out.last	<= 0;
		end
		else if (ld_odd)
		begin
			out.dat		<= odd;
			out.last	<= (op.op == OP_FLUSH);		// End of line
		end
	end

// Sequencer
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			state	<= SND_IDLE;
			op.ack	<= 0;
			out.req	<= 0;
		end
		else
		begin
			case (state)
				SND_IDLE :
				begin
					if (ld_prev)
					begin
						op.ack	<= 1;		// Load needs no output
						state	<= SND_DONE;
					end
					else if (ld_even)
					begin
						out.req	<= 1;
						state	<= SND_EVEN;
					end
				end
				SND_EVEN :
				begin
					if (out.ack)
					begin
						out.req	<= 0;
						state	<= SND_EVEN_DROP;
					end
				end
				SND_EVEN_DROP :
				begin
					if (ld_odd)
					begin
						out.req	<= 1;
						state	<= SND_ODD;
					end
				end
				SND_ODD :
				begin
					if (out.ack)
					begin
						out.req	<= 0;
						state	<= SND_ODD_DROP;
					end
				end
				SND_ODD_DROP :
				begin
					// Both handshakes complete
					if (!out.ack)
					begin
						op.ack	<= 1;
						state	<= SND_DONE;
					end
				end
				default :
				begin
					if (!op.req)
					begin
						op.ack	<= 0;
						state	<= SND_IDLE;
					end
				end
			endcase
		end
	end

// Head held by control until the pair is acked
	assert property (@(posedge RST_IN) disable iff (CLK_IN)
		(op.req && !op.ack && (op.op == OP_PAIR)) |=> $stable(head))
		else $error("FIFO head changed during a pending pair");

endmodule

`default_nettype wire

// File: src/scaler_out_port.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_out_port
(
	input wire					RST_IN,		// Clock
	input wire					CLK_IN,		// Reset
	pix_if.receiver				in,			// Pixels from interpolator
	output logic				out_req,	// Output pixel request
	input wire					out_ack,	// Output pixel acknowledge
	output scaler_pkg::pixel_t	out_dat,	// Output pixel
	output logic				out_last	// Last pixel of line
);

logic take;		// New pixel offered and output idle

	assign take = in.req && !in.ack && !out_req;

// Pixel and last flag
	always_ff @(posedge RST_IN)
	begin
		if (take)
		begin
			out_dat		<= in.dat;
			out_last	<= in.last;
		end
	end

// Handshake relay
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
		begin
			out_req	<= 0;
			in.ack	<= 0;
		end
		else
		begin
			if (take)
				out_req <= 1;
			else if (out_req && in.ack && !in.req)
				out_req <= 0;		// Follows the internal req

			if (out_req && out_ack && !in.ack)
				in.ack <= 1;
			else if (in.ack && !out_req && !out_ack)
				in.ack <= 0;		// Output side fully released
		end
	end

endmodule

`default_nettype wire

// File: src/scaler_pkg.sv
`default_nettype none

package scaler_pkg;

	typedef logic [7:0] comp_t;		// One colour component

	// RGB pixel, red in the upper byte
	typedef struct packed
	{
		comp_t r;
		comp_t g;
		comp_t b;
	} pixel_t;

	// Horizontal interpolation mode, sampled per line
	typedef enum logic
	{
		MODE_NEAREST,				// Odd pixel copies the even one
		MODE_LINEAR					// Odd pixel is the rounded average
	} scale_mode_t;

	// Opcodes from control to interpolator
	typedef enum logic [1:0]
	{
		OP_LOAD,					// Latch head, no output
		OP_PAIR,					// Even and odd pixel, then latch head
		OP_FLUSH					// Previous pixel twice, second one last
	} interp_op_t;

	// Line control FSM
	typedef enum logic [1:0]
	{
		ST_IDLE,					// Waiting for first pixel of a line
		ST_ISSUE,					// Waiting for next pixel in FIFO
		ST_WAIT_ACK,				// Opcode request pending
		ST_WAIT_DROP				// Waiting for ack release
	} ctl_state_t;

endpackage

`default_nettype wire

// File: src/scaler_top.sv
`timescale 1ns/1ps
`default_nettype none

module scaler_top
#(
	parameter P_LINE_LEN = 16,		// Input pixels per line
	parameter P_FIFO_ADR = 3		// FIFO address width
)
(
	input wire							RST_IN,		// Clock
	input wire							CLK_IN,		// Reset

	// Input stream
	input wire							in_req,
	output logic						in_ack,
	input wire scaler_pkg::pixel_t		in_dat,

	// Output stream
	output logic						out_req,
	input wire							out_ack,
	output scaler_pkg::pixel_t			out_dat,
	output logic						out_last,

	input wire scaler_pkg::scale_mode_t	mode		// Interpolation mode
);

import scaler_pkg::*;

logic	wr;			// FIFO write
pixel_t	wr_dat;		// FIFO write data
logic	full;		// FIFO full
logic	rd;			// FIFO pop
logic	empty;		// FIFO empty
pixel_t	head;		// FIFO head

op_if	iop ();		// Control to interpolator
pix_if	ipx ();		// Interpolator to output port

	scaler_in_port in_port_inst
	(
		.RST_IN	(RST_IN),
		.CLK_IN	(CLK_IN),
		.in_req	(in_req),
		.in_ack	(in_ack),
		.in_dat	(in_dat),
		.full	(full),
		.wr		(wr),
		.wr_dat	(wr_dat)
	);

	scaler_fifo #(.P_FIFO_ADR (P_FIFO_ADR)) fifo_inst
	(
		.RST_IN	(RST_IN),
		.CLK_IN	(CLK_IN),
		.wr		(wr),
		.wr_dat	(wr_dat),
		.rd		(rd),
		.head	(head),
		.empty	(empty),
		.full	(full)
	);

	scaler_ctl #(.P_LINE_LEN (P_LINE_LEN)) ctl_inst
	(
		.RST_IN	(RST_IN),
		.CLK_IN	(CLK_IN),
		.mode	(mode),
		.empty	(empty),
		.rd		(rd),
		.op		(iop)
	);

	scaler_interp interp_inst
	(
		.RST_IN	(RST_IN),
		.CLK_IN	(CLK_IN),
		.head	(head),
		.op		(iop),
		.out	(ipx)
	);

	scaler_out_port out_port_inst
	(
		.RST_IN		(RST_IN),
		.CLK_IN		(CLK_IN),
		.in			(ipx),
		.out_req	(out_req),
		.out_ack	(out_ack),
		.out_dat	(out_dat),
		.out_last	(out_last)
	);

endmodule

`default_nettype wire

// File: tb/tb_scaler.sv
`timescale 1ns/1ps
`default_nettype none

module tb_scaler;

import scaler_pkg::*;

localparam P_LINE_LEN	= 16;						// Input pixels per line
localparam P_FIFO_ADR	= 3;
localparam P_NUM_LINES	= 8;
localparam P_TOTAL		= P_NUM_LINES * 2 * P_LINE_LEN;	// Output pixels in the run
localparam P_TMO		= 2000;						// Cycles allowed per wait

logic			RST_IN;		// Clock
logic			CLK_IN;		// Reset
logic			in_req;
logic			in_ack;
pixel_t			in_dat;
logic			out_req;
logic			out_ack;
pixel_t			out_dat;
logic			out_last;
scale_mode_t	mode;

pixel_t	exp_dat_q [$];		// Expected pixels, in output order
logic	exp_last_q [$];		// Expected last flags
int		n_out;				// Output pixels taken

	scaler_top #(.P_LINE_LEN (P_LINE_LEN), .P_FIFO_ADR (P_FIFO_ADR)) scaler_top_inst
	(
		.RST_IN		(RST_IN),
		.CLK_IN		(CLK_IN),
		.in_req		(in_req),
		.in_ack		(in_ack),
		.in_dat		(in_dat),
		.out_req	(out_req),
		.out_ack	(out_ack),
		.out_dat	(out_dat),
		.out_last	(out_last),
		.mode		(mode)
	);

	initial
	begin
		RST_IN = 1'b0;
		forever #10 RST_IN = ~RST_IN;		// 20 ns period
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "Simulation stopped");
	endtask

// Edge plus a small hold, all driving and sampling happens here
	task automatic next_cycle();
		@(posedge RST_IN);
		#2;
	endtask

	task automatic check_pixel(input pixel_t got, input pixel_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] out_dat: got 0x%06h, expected 0x%06h (pixel %0d)",
				got, exp, n_out));
	endtask

	task automatic check_last(input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] out_last: got 0x%0h, expected 0x%0h (pixel %0d)",
				got, exp, n_out));
	endtask

	task automatic check_low(input string name, input logic got);
		if (got !== 1'b0)
			abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x0", name, got));
	endtask

// Rounded mean of two components
	function automatic comp_t mean(input comp_t a, input comp_t b);
		int s;
		s = int'(a) + int'(b) + 1;
		return comp_t'(s / 2);
	endfunction

// Expected output of one line
	function automatic void ref_line(input pixel_t src [P_LINE_LEN], input scale_mode_t m,
		output pixel_t dst [2*P_LINE_LEN], output logic lst [2*P_LINE_LEN]);
		int i;
		for (i = 0; i < P_LINE_LEN; i++)
		begin
			dst[2*i]	= src[i];		// Even is the pixel itself
			lst[2*i]	= 1'b0;
			if ((i == P_LINE_LEN - 1) || (m == MODE_NEAREST))
				dst[2*i+1] = src[i];	// Copy, or line end duplicate
			else
			begin
				dst[2*i+1].r = mean(src[i].r, src[i+1].r);
				dst[2*i+1].g = mean(src[i].g, src[i+1].g);
				dst[2*i+1].b = mean(src[i].b, src[i+1].b);
			end
			lst[2*i+1] = (i == P_LINE_LEN - 1);
		end
	endfunction

// One four-phase input transfer
	task automatic drive_pixel(input pixel_t p);
		int t;
		in_dat	= p;
		in_req	= 1'b1;
		t = 0;
		while (!in_ack)
		begin
			next_cycle();
			t++;
			if (t > P_TMO)
				abort_run("Timeout: in_ack did not rise for an input pixel");
		end
		in_req = 1'b0;
		t = 0;
		while (in_ack)
		begin
			next_cycle();
			t++;
			if (t > P_TMO)
				abort_run("Timeout: in_ack did not fall after in_req was released");
		end
	endtask

	task automatic drive_lines();
		pixel_t			line [P_LINE_LEN];
		pixel_t			exp_px [2*P_LINE_LEN];
		logic			exp_ls [2*P_LINE_LEN];
		scale_mode_t	m;
		int				ln;
		int				i;
		for (ln = 0; ln < P_NUM_LINES; ln++)
		begin
			// Fixed modes first so the mode surely changes
			if ((ln == 0) || (ln == 2))
				m = MODE_LINEAR;
			else if (ln == 1)
				m = MODE_NEAREST;
			else
				m = ($urandom_range(1) == 0) ? MODE_NEAREST : MODE_LINEAR;
			for (i = 0; i < P_LINE_LEN; i++)
			begin
				if (ln == 0)
					line[i] = (i % 2 == 1) ? 24'hFF00FF : 24'h00FF00;	// Extremes side by side
				else
					line[i] = 24'($urandom);
			end
			ref_line(line, m, exp_px, exp_ls);
			for (i = 0; i < 2 * P_LINE_LEN; i++)
			begin
				exp_dat_q.push_back(exp_px[i]);
				exp_last_q.push_back(exp_ls[i]);
			end
			mode = m;		// Only between lines
			for (i = 0; i < P_LINE_LEN; i++)
			begin
				if ((ln != 4) && (ln != 5))
					repeat ($urandom_range(3)) next_cycle();	// No gaps under back-pressure
				drive_pixel(line[i]);
			end
		end
	endtask

// Take one output pixel, compare, then ack after a random delay
	task automatic take_output(input logic slow);
		int		t;
		int		dly;
		pixel_t	got_dat;
		logic	got_last;
		t = 0;
		while (!out_req)
		begin
			next_cycle();
			t++;
			if (t > P_TMO)
				abort_run("Timeout: out_req did not rise for the next output pixel");
		end
		got_dat		= out_dat;
		got_last	= out_last;
		if (exp_dat_q.size() == 0)
			abort_run("Output pixel appeared with nothing expected");
		check_pixel(got_dat, exp_dat_q.pop_front());
		check_last(got_last, exp_last_q.pop_front());
		dly = slow ? int'($urandom_range(24)) : int'($urandom_range(2));
		repeat (dly) next_cycle();
		out_ack = 1'b1;
		t = 0;
		while (out_req)
		begin
			next_cycle();
			t++;
			if (t > P_TMO)
				abort_run("Timeout: out_req did not fall after out_ack");
		end
		out_ack = 1'b0;
		n_out++;
	endtask

	task automatic collect_outputs();
		int ln;
		while (n_out < P_TOTAL)
		begin
			ln = n_out / (2 * P_LINE_LEN);
			take_output((ln == 4) || (ln == 5));		// Long ack delays on two lines
		end
	endtask

	initial
	begin
		void'($urandom(2));
		in_req	= 1'b0;
		in_dat	= '0;
		out_ack	= 1'b0;
		mode	= MODE_NEAREST;
		n_out	= 0;
		CLK_IN	= 1'b1;
		repeat (10) @(posedge RST_IN);
		#2;
		CLK_IN = 1'b0;

		// Quiet outputs before any input
		repeat (20)
		begin
			next_cycle();
			check_low("in_ack", in_ack);
			check_low("out_req", out_req);
		end

		fork
			drive_lines();
			collect_outputs();
		join

		// No stray pixel after the last line
		repeat (40)
		begin
			next_cycle();
			check_low("out_req", out_req);
			check_low("in_ack", in_ack);
		end

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire
